// ==== run_sim.sh ====
#!/bin/sh
# build and run the weight loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f \
    --top-module weight_load_tb -o weight_load_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/weight_load_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1

// ==== sim/weight_load_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module weight_load_props #(
  parameter int hw = 1
) (
  input logic          clk,
  input logic          reset,
  input logic          busy,
  input logic          done,
  input logic          we,
  input logic          push,
  input logic          full,
  input logic          pop,
  input logic          empty,
  input logic [hw-1:0] head
);

  //////////////////////////////////////////////////////////////////////
  // loader control
  //////////////////////////////////////////////////////////////////////

  a_done_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
    else $error("done pulsed while the loader was idle");

  // last write lands before the done cycle
  a_we_busy: assert property (@(posedge clk) disable iff (reset) we |-> (busy && !done))
    else $error("buffer write while the loader was idle or already done");

  //////////////////////////////////////////////////////////////////////
  // fifo rules
  //////////////////////////////////////////////////////////////////////

  a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("push into a full FIFO");

  // head waiting for ready must not move
  a_head_stable: assert property (@(posedge clk) disable iff (reset)
                                  (!empty && !pop) |=> $stable(head))
    else $error("FIFO head changed while waiting for a pop");

endmodule

bind weight_load_ctrl weight_load_props u_ctrl_props (
  .clk   (clk),
  .reset (reset),
  .busy  (busy),
  .done  (done),
  .we    (buf_we),
  .push  (1'b0),
  .full  (1'b0),
  .pop   (1'b0),
  .empty (1'b1),
  .head  (1'b0)
);

bind sync_fifo weight_load_props #(.hw($bits(pop_data))) u_fifo_props (
  .clk   (clk),
  .reset (reset),
  .busy  (1'b1),
  .done  (1'b0),
  .we    (1'b0),
  .push  (push),
  .full  (full),
  .pop   (pop),
  .empty (empty),
  .head  (pop_data)
);

`default_nettype wire

// ==== sim/weight_load_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wl_consts.svh"

module weight_load_tb;

  typedef struct {
    logic [3:0]  mode;
    int          nkk;
    int          of;
    logic [31:0] base;
    int          ready_pct;
    int          cmds;
    bit          poke;
  } test_row_t;

  localparam int n_tests = 8;
  localparam logic [31:0] data_mask = 32'h5a5a_0000;

  logic                  clk;
  logic                  reset;
  logic                  start;
  logic [3:0]            cfg_mode;
  logic [`WL_ADDR_W-1:0] cfg_nkk;
  logic [`WL_LEN_W-1:0]  cfg_of;
  logic [`WL_ADDR_W-1:0] cfg_base;
  logic                  busy;
  logic                  done;
  logic                  ddr_cmd_valid;
  logic                  ddr_cmd_ready = 1'b0;
  logic [`WL_ADDR_W-1:0] ddr_cmd_addr;
  logic [`WL_LEN_W-1:0]  ddr_cmd_len;
  logic                  ddr_rd_valid = 1'b0;
  logic [`WL_DATA_W-1:0] ddr_rd_data = '0;
  logic                  buf_rd_en;
  logic [`WL_BUF_AW-1:0] buf_rd_addr;
  logic [`WL_DATA_W-1:0] buf_rd_data;

  test_row_t             tests [n_tests];
  int                    errors = 0;
  int                    cmd_seen = 0;
  int                    ready_pct = 100;

  // expected command stream, and accepted commands waiting for data
  logic [31:0]           exp_addr_q [$];
  logic [15:0]           exp_len_q [$];
  logic [31:0]           pend_addr_q [$];
  logic [15:0]           pend_len_q [$];
  logic [31:0]           burst_addr;
  int                    burst_left = 0;
  int                    wait_cnt = 0;

  weight_load_top u_weight_load_top (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .cfg_mode      (cfg_mode),
    .cfg_nkk       (cfg_nkk),
    .cfg_of        (cfg_of),
    .cfg_base      (cfg_base),
    .busy          (busy),
    .done          (done),
    .ddr_cmd_valid (ddr_cmd_valid),
    .ddr_cmd_ready (ddr_cmd_ready),
    .ddr_cmd_addr  (ddr_cmd_addr),
    .ddr_cmd_len   (ddr_cmd_len),
    .ddr_rd_valid  (ddr_rd_valid),
    .ddr_rd_data   (ddr_rd_data),
    .buf_rd_en     (buf_rd_en),
    .buf_rd_addr   (buf_rd_addr),
    .buf_rd_data   (buf_rd_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // test table and layer arithmetic
  //////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    // mode, nkk, of, base, ready %, commands, mid-load start
    tests[0] = '{4'd0, 20, 50, 32'h0000_1000, 100, 1, 1'b0};
    tests[1] = '{4'd0, 70, 64, 32'h0002_0000, 100, 3, 1'b0};
    tests[2] = '{4'd0, 40, 200, 32'h0003_0100, 100, 8, 1'b1};
    tests[3] = '{4'd1, 40, 200, 32'h0004_0200, 100, 4, 1'b0};
    tests[4] = '{4'd5, 40, 200, 32'h0005_0300, 100, 8, 1'b0};
    tests[5] = '{4'd0, 70, 130, 32'h0006_0000, 100, 9, 1'b0};
    tests[6] = '{4'd0, 70, 130, 32'h0016_0000, 30, 9, 1'b1};
    tests[7] = '{4'd1, 33, 256, 32'h0007_fff0, 50, 4, 1'b1};
  endtask

  function automatic int tiles_for(input int idx);
    int rows;
    // anything but mode 1 uses the narrow tile
    rows = (tests[idx].mode == 4'd1) ? 128 : 64;
    return (tests[idx].of + rows - 1) / rows;
  endfunction

  task automatic build_expected(input int idx);
    int t;
    int off;
    int len;
    exp_addr_q.delete();
    exp_len_q.delete();
    for (t = 0; t < tiles_for(idx); t++) begin
      off = 0;
      while (off < tests[idx].nkk) begin
        len = (tests[idx].nkk - off > 32) ? 32 : tests[idx].nkk - off;
        exp_addr_q.push_back(tests[idx].base + 32'(t * tests[idx].nkk + off));
        exp_len_q.push_back(16'(len));
        off += len;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // ddr model
  //////////////////////////////////////////////////////////////////////

  task automatic check_command();
    logic [31:0] ea;
    logic [15:0] el;
    cmd_seen++;
    if (exp_addr_q.size() == 0) begin
      $display("unexpected extra DDR command at time %0t, addr %h", $time, ddr_cmd_addr);
      errors++;
    end else begin
      ea = exp_addr_q.pop_front();
      el = exp_len_q.pop_front();
      if (ddr_cmd_addr !== ea || ddr_cmd_len !== el) begin
        $display("FAIL %0t: command addr %h len %0d, expected addr %h len %0d",
                 $time, ddr_cmd_addr, ddr_cmd_len, ea, el);
        errors++;
      end
    end
    pend_addr_q.push_back(ddr_cmd_addr);
    pend_len_q.push_back(ddr_cmd_len);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      ddr_cmd_ready <= 1'b0;
      ddr_rd_valid  <= 1'b0;
      burst_left = 0;
      wait_cnt = 0;
      pend_addr_q.delete();
      pend_len_q.delete();
    end else begin
      ddr_cmd_ready <= (int'($urandom % 100) < ready_pct);
      ddr_rd_valid  <= 1'b0;
      if (ddr_cmd_valid && ddr_cmd_ready) begin
        check_command();
      end
      if (burst_left == 0 && pend_addr_q.size() > 0) begin
        burst_addr = pend_addr_q.pop_front();
        burst_left = int'(pend_len_q.pop_front());
        wait_cnt = int'($urandom % 6);
      end else if (burst_left > 0) begin
        if (wait_cnt > 0) begin
          wait_cnt--;
        end else begin
          ddr_rd_valid <= 1'b1;
          ddr_rd_data  <= burst_addr ^ data_mask;
          burst_addr = burst_addr + 32'd1;
          burst_left--;
          // gap before the next word
          wait_cnt = int'($urandom % 3);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // one load, then buffer readback
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int idx, output bit ok);
    int err_before;
    int words;
    int cyc;
    int done_cnt;
    logic [31:0] expect_val;
    err_before = errors;
    words = tiles_for(idx) * tests[idx].nkk;
    build_expected(idx);
    cmd_seen = 0;
    ready_pct = tests[idx].ready_pct;
    @(posedge clk);
    if (busy !== 1'b0) begin
      $display("busy was already high before start of test %0d", idx);
      errors++;
    end
    start    <= 1'b1;
    cfg_mode <= tests[idx].mode;
    cfg_nkk  <= tests[idx].nkk;
    cfg_of   <= 16'(tests[idx].of);
    cfg_base <= tests[idx].base;
    @(posedge clk);
    start <= 1'b0;
    done_cnt = 0;
    cyc = 0;
    while (done_cnt == 0) begin
      @(posedge clk);
      cyc++;
      if (busy !== 1'b1) begin
        $display("busy dropped before done in test %0d at time %0t", idx, $time);
        errors++;
      end
      if (done === 1'b1) begin
        done_cnt++;
      end
      // second start with another layer while the load runs
      if (tests[idx].poke && cyc == 6 && done !== 1'b1) begin
        start    <= 1'b1;
        cfg_mode <= 4'd1;
        cfg_nkk  <= 32'd5;
        cfg_of   <= 16'd1;
        cfg_base <= 32'h00ab_0000;
      end else begin
        start <= 1'b0;
      end
    end
    repeat (3) begin
      @(posedge clk);
      if (done !== 1'b0) begin
        $display("done pulsed more than once in test %0d", idx);
        errors++;
      end
      if (busy !== 1'b0) begin
        $display("busy still high after done in test %0d", idx);
        errors++;
      end
    end
    if (cmd_seen != tests[idx].cmds) begin
      $display("FAIL %0t: %0d commands, expected %0d", $time, cmd_seen, tests[idx].cmds);
      errors++;
    end
    if (exp_addr_q.size() != 0) begin
      $display("test %0d ended with %0d commands never issued", idx, exp_addr_q.size());
      errors++;
    end
    // read data checked two edges after its address
    for (cyc = 0; cyc < words + 2; cyc++) begin
      @(posedge clk);
      if (cyc >= 2) begin
        expect_val = (tests[idx].base + 32'(cyc - 2)) ^ data_mask;
        if (buf_rd_data !== expect_val) begin
          $display("FAIL %0t: buffer addr %0d holds %h, expected %h",
                   $time, cyc - 2, buf_rd_data, expect_val);
          errors++;
        end
      end
      if (cyc < words) begin
        buf_rd_en   <= 1'b1;
        buf_rd_addr <= `WL_BUF_AW'(cyc);
      end else begin
        buf_rd_en <= 1'b0;
      end
    end
    ok = (errors == err_before);
    $display("test %0d mode %0d nkk %0d of %0d ready %0d%%: %0d commands, %0d words, %s",
             idx, tests[idx].mode, tests[idx].nkk, tests[idx].of, tests[idx].ready_pct,
             cmd_seen, words, ok ? "passed" : "failed");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int passed;
    int failed;
    bit ok;
    void'($urandom(32'hc15dce38));
    fill_table();
    reset       = 1'b1;
    start       = 1'b0;
    cfg_mode    = '0;
    cfg_nkk     = '0;
    cfg_of      = '0;
    cfg_base    = '0;
    buf_rd_en   = 1'b0;
    buf_rd_addr = '0;
    passed = 0;
    failed = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    if (busy !== 1'b0 || done !== 1'b0 || ddr_cmd_valid !== 1'b0) begin
      $display("busy, done or ddr_cmd_valid not low after reset");
      errors++;
    end
    for (i = 0; i < n_tests; i++) begin
      run_test(i, ok);
      if (ok) begin
        passed++;
      end else begin
        failed++;
      end
    end
    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    int i;
    #1;
    limit = 1000;
    for (i = 0; i < n_tests; i++) begin
      limit += 200 * tests[i].cmds;
    end
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/wl_pkg.sv
src/sync_fifo.sv
src/weight_load_ctrl.sv
src/weight_buf.sv
src/weight_load_top.sv
sim/weight_load_props.sv
sim/weight_load_tb.sv

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wl_consts.svh"

module sync_fifo #(
  parameter type payload_t = logic [`WL_DATA_W-1:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);

  localparam logic [aw-1:0] last_slot = aw'(depth - 1);
  localparam logic [cw-1:0] full_cnt  = cw'(depth);

  payload_t        mem [depth];
  logic [aw-1:0]   wr_ptr;
  logic [aw-1:0]   rd_ptr;
  logic [cw-1:0]   count;
  logic            push_ok;
  logic            pop_ok;

  // overflow and underflow requests are dropped here
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  assign full     = (count == full_cnt);
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // pointers and fill level
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/weight_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wl_consts.svh"

module weight_buf (
  input  logic                  clk,
  input  logic                  we,
  input  logic [`WL_BUF_AW-1:0] waddr,
  input  wl_pkg::weight_word_t  wdata,
  input  logic                  rd_en,
  input  logic [`WL_BUF_AW-1:0] raddr,
  output wl_pkg::weight_word_t  rdata
);
  import wl_pkg::*;

  ////////////////////////////////////////////////////////////////////////
  // weight storage
  ////////////////////////////////////////////////////////////////////////

  weight_word_t mem [`WL_BUF_DEPTH];

  // loader side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // compute side read port
  ////////////////////////////////////////////////////////////////////////

  // data valid the cycle after rd_en, held otherwise
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// ==== src/weight_load_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wl_consts.svh"

module weight_load_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  wl_pkg::conv_mode_t    cfg_mode,
  input  logic [`WL_ADDR_W-1:0] cfg_nkk,
  input  logic [`WL_LEN_W-1:0]  cfg_of,
  input  logic [`WL_ADDR_W-1:0] cfg_base,
  output logic                  cmd_push,
  output wl_pkg::ddr_cmd_t      cmd_data,
  input  logic                  cmd_full,
  input  logic                  rd_empty,
  output logic                  rd_pop,
  output logic                  buf_we,
  output logic [`WL_BUF_AW-1:0] buf_waddr,
  output logic                  busy,
  output logic                  done
);
  import wl_pkg::*;

  localparam logic [`WL_LEN_W-1:0]  rows_m0   = `WL_ROWS_MODE0;
  localparam logic [`WL_LEN_W-1:0]  rows_m1   = `WL_ROWS_MODE1;
  localparam logic [`WL_ADDR_W-1:0] burst_max = `WL_BURST_MAX;

  // layer config, captured on start
  conv_mode_t            mode_q;
  logic [`WL_ADDR_W-1:0] nkk_q;
  logic [`WL_LEN_W-1:0]  of_q;
  logic [`WL_ADDR_W-1:0] base_q;

  // tile and burst walk
  logic [`WL_LEN_W-1:0]  rows;
  logic [`WL_LEN_W-1:0]  tile_start;
  logic [`WL_ADDR_W-1:0] tile_base;
  logic [`WL_ADDR_W-1:0] word_off;
  logic [`WL_ADDR_W-1:0] remain;
  logic [`WL_LEN_W-1:0]  cmd_len;
  logic                  tile_last;
  logic                  word_last;
  logic                  issue_all;

  // outstanding command tracking
  logic                  cmd_out;
  logic [`WL_LEN_W-1:0]  shadow_len;
  logic [`WL_LEN_W-1:0]  pop_cnt;
  logic                  pop_last;
  logic                  start_ok;

  assign start_ok = start && !busy;

  ////////////////////////////////////////////////////////////////////////
  // command generation
  ////////////////////////////////////////////////////////////////////////

  // unknown modes fall back to the narrow tile
  assign rows = (mode_q == 4'd1) ? rows_m1 : rows_m0;

  // last tile once this tile reaches or passes of
  assign tile_last = ({1'b0, tile_start} + {1'b0, rows}) >= {1'b0, of_q};

  assign remain    = nkk_q - word_off;
  assign word_last = (remain <= burst_max);
  assign cmd_len   = word_last ? remain[`WL_LEN_W-1:0] : burst_max[`WL_LEN_W-1:0];

  assign cmd_data.addr = base_q + tile_base + word_off;
  assign cmd_data.len  = cmd_len;

  // one command in flight at a time
  assign cmd_push = busy && !cmd_out && !issue_all && !cmd_full;

  ////////////////////////////////////////////////////////////////////////
  // read data drain
  ////////////////////////////////////////////////////////////////////////

  assign rd_pop   = busy && !rd_empty;
  assign buf_we   = rd_pop;
  assign pop_last = rd_pop && (pop_cnt + 1'b1 == shadow_len);

  always_ff @(posedge clk) begin
    if (start_ok) begin
      mode_q <= cfg_mode;
      nkk_q  <= cfg_nkk;
      of_q   <= cfg_of;
      base_q <= cfg_base;
    end
  end

  // busy holds through the done cycle and drops with it
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= issue_all && pop_last;
      if (start_ok) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // tile / word offset walk, advanced per accepted push
  always_ff @(posedge clk) begin
    if (reset || start_ok) begin
      tile_start <= '0;
      tile_base  <= '0;
      word_off   <= '0;
      issue_all  <= 1'b0;
    end else if (cmd_push) begin
      if (word_last) begin
        word_off <= '0;
        if (tile_last) begin
          issue_all <= 1'b1;
        end else begin
          tile_start <= tile_start + rows;
          tile_base  <= tile_base + nkk_q;
        end
      end else begin
        word_off <= word_off + cmd_len;
      end
    end
  end

  // shadow length of the command in flight
  always_ff @(posedge clk) begin
    if (reset || start_ok) begin
      cmd_out    <= 1'b0;
      shadow_len <= '0;
      pop_cnt    <= '0;
    end else begin
      if (cmd_push) begin
        cmd_out    <= 1'b1;
        shadow_len <= cmd_len;
      end
      if (rd_pop) begin
        if (pop_last) begin
          pop_cnt <= '0;
          cmd_out <= 1'b0;
        end else begin
          pop_cnt <= pop_cnt + 1'b1;
        end
      end
    end
  end

  // buffer address runs across all tiles
  always_ff @(posedge clk) begin
    if (reset || start_ok) begin
      buf_waddr <= '0;
    end else if (buf_we) begin
      buf_waddr <= buf_waddr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/weight_load_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wl_consts.svh"

module weight_load_top (
  input  logic                  clk,
  input  logic                  reset,
  // layer control
  input  logic                  start,
  input  wl_pkg::conv_mode_t    cfg_mode,
  input  logic [`WL_ADDR_W-1:0] cfg_nkk,
  input  logic [`WL_LEN_W-1:0]  cfg_of,
  input  logic [`WL_ADDR_W-1:0] cfg_base,
  output logic                  busy,
  output logic                  done,
  // ddr command port
  output logic                  ddr_cmd_valid,
  input  logic                  ddr_cmd_ready,
  output logic [`WL_ADDR_W-1:0] ddr_cmd_addr,
  output logic [`WL_LEN_W-1:0]  ddr_cmd_len,
  // ddr read data
  input  logic                  ddr_rd_valid,
  input  wl_pkg::weight_word_t  ddr_rd_data,
  // compute side buffer read
  input  logic                  buf_rd_en,
  input  logic [`WL_BUF_AW-1:0] buf_rd_addr,
  output wl_pkg::weight_word_t  buf_rd_data
);
  import wl_pkg::*;

  logic                  cmd_push;
  ddr_cmd_t              cmd_data;
  logic                  cmd_full;
  ddr_cmd_t              cmd_head;
  logic                  cmd_empty;
  logic                  rd_pop;
  logic                  rd_empty;
  weight_word_t          rd_head;
  logic                  buf_we;
  logic [`WL_BUF_AW-1:0] buf_waddr;

  weight_load_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .cfg_mode  (cfg_mode),
    .cfg_nkk   (cfg_nkk),
    .cfg_of    (cfg_of),
    .cfg_base  (cfg_base),
    .cmd_push  (cmd_push),
    .cmd_data  (cmd_data),
    .cmd_full  (cmd_full),
    .rd_empty  (rd_empty),
    .rd_pop    (rd_pop),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .busy      (busy),
    .done      (done)
  );

  ////////////////////////////////////////////////////////////////////////
  // ddr command queue
  ////////////////////////////////////////////////////////////////////////

  sync_fifo #(.payload_t(ddr_cmd_t), .depth(4)) u_cmd_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (cmd_push),
    .push_data (cmd_data),
    .full      (cmd_full),
    .pop       (ddr_cmd_ready),
    .pop_data  (cmd_head),
    .empty     (cmd_empty)
  );

  // head entry stays on the port until ready
  assign ddr_cmd_valid = !cmd_empty;
  assign ddr_cmd_addr  = cmd_head.addr;
  assign ddr_cmd_len   = cmd_head.len;

  ////////////////////////////////////////////////////////////////////////
  // read data queue and buffer
  ////////////////////////////////////////////////////////////////////////

  // no back-pressure toward ddr
  sync_fifo #(.payload_t(weight_word_t), .depth(`WL_RD_FIFO_DEPTH)) u_rd_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (ddr_rd_valid),
    .push_data (ddr_rd_data),
    .full      (),
    .pop       (rd_pop),
    .pop_data  (rd_head),
    .empty     (rd_empty)
  );

  weight_buf u_buf (
    .clk   (clk),
    .we    (buf_we),
    .waddr (buf_waddr),
    .wdata (rd_head),
    .rd_en (buf_rd_en),
    .raddr (buf_rd_addr),
    .rdata (buf_rd_data)
  );

endmodule

`default_nettype wire

// ==== src/wl_consts.svh ====
`ifndef WL_CONSTS_SVH
`define WL_CONSTS_SVH

// ddr side widths, in words
`define WL_ADDR_W 32
`define WL_DATA_W 32
`define WL_LEN_W 16

// longest single read command
`define WL_BURST_MAX 32

// output channels per tile for each mode
`define WL_ROWS_MODE0 64
`define WL_ROWS_MODE1 128

// on-chip weight buffer
`define WL_BUF_DEPTH 1024
`define WL_BUF_AW 10

// read data queue holds two full bursts
`define WL_RD_FIFO_DEPTH 64

`endif

// ==== src/wl_pkg.sv ====
`default_nettype none

`include "wl_consts.svh"

package wl_pkg;

  //////////////////////////////////////////////////////////////////////
  // layer configuration
  //////////////////////////////////////////////////////////////////////

  // only 1 selects the wide tile, everything else acts as mode 0
  typedef logic [3:0] conv_mode_t;

  //////////////////////////////////////////////////////////////////////
  // ddr traffic
  //////////////////////////////////////////////////////////////////////

  // one weight as it comes back from ddr
  typedef logic [`WL_DATA_W-1:0] weight_word_t;

  // read command, word address plus word count
  typedef struct packed {
    logic [`WL_ADDR_W-1:0] addr;
    logic [`WL_LEN_W-1:0]  len;
  } ddr_cmd_t;

endpackage

`default_nettype wire
